/* hdl/raster_consts.svh */
// Screen size and buffer depths are fixed at build time; address widths must match the depths
`ifndef RASTER_CONSTS_SVH
`define RASTER_CONSTS_SVH

// Signed coordinate width
`define RASTER_DATAWIDTH 12

// Screen in pixels, origin at the top left
`define RASTER_SCREEN_WIDTH 320
`define RASTER_SCREEN_HEIGHT 320

`define RASTER_MAX_VERTICES 256   // Vertex buffer depth
`define RASTER_MAX_TRIANGLES 128  // Index buffer depth

// Must be clog2 of the depths above
`define RASTER_VADDR_W 8
`define RASTER_TADDR_W 7

`endif

/* hdl/raster_pkg.sv */
// Vertex coordinates are signed screen space values; the invalid bit rejects the whole triangle
package raster_pkg;

`include "raster_consts.svh"

    // One transformed vertex, 37 bits
    typedef struct packed {
        logic signed [`RASTER_DATAWIDTH-1:0] x;
        logic signed [`RASTER_DATAWIDTH-1:0] y;
        logic signed [`RASTER_DATAWIDTH-1:0] z;
        logic                                invalid; // Set by transform, never rendered
    } vertex_t;

    // Assembled triangle, corners in index order
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Three vertex buffer addresses per triangle
    typedef struct packed {
        logic [`RASTER_VADDR_W-1:0] i0;
        logic [`RASTER_VADDR_W-1:0] i1;
        logic [`RASTER_VADDR_W-1:0] i2;
    } index_entry_t;

endpackage

/* hdl/index_buffer.sv */
// Count must be 1 to MAX_TRIANGLES; do not write while the assembler is reading
`timescale 1ns/1ns

`include "raster_consts.svh"

module index_buffer
    import raster_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,

    input  logic                       i_wr,
    input  logic [`RASTER_TADDR_W-1:0] i_waddr,
    input  index_entry_t               i_wdata,

    input  logic [`RASTER_TADDR_W:0]   i_count,  // Number of triangles in the list
    input  logic                       i_rewind,
    input  logic                       i_read_en,

    output index_entry_t               o_entry,
    output logic                       o_dv,
    output logic                       o_last
);

    index_entry_t mem [`RASTER_MAX_TRIANGLES];

    logic [`RASTER_TADDR_W-1:0] r_ptr;
    logic [`RASTER_TADDR_W:0]   last_pos;

    assign last_pos = i_count - 1'b1;

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[i_waddr] <= i_wdata;
        end
        if (i_read_en) begin
            o_entry <= mem[r_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_ptr  <= '0;
            o_dv   <= 1'b0;
            o_last <= 1'b0;
        end else begin
            o_dv <= i_read_en;
            if (i_rewind) begin
                r_ptr <= '0;
            end else if (i_read_en) begin
                r_ptr <= r_ptr + 1'b1;
            end
            if (i_read_en) begin
                o_last <= ({1'b0, r_ptr} == last_pos);
            end
        end
    end

endmodule

/* hdl/vertex_buffer.sv */
// Three reads share one write port; data is ready one cycle after the read enable
`timescale 1ns/1ns

`include "raster_consts.svh"

module vertex_buffer
    import raster_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,

    input  logic                       i_wr,
    input  logic [`RASTER_VADDR_W-1:0] i_waddr,
    input  vertex_t                    i_wdata,

    input  index_entry_t               i_raddr,   // One address per corner
    input  logic                       i_read_en,

    output triangle_t                  o_tri,
    output logic                       o_dv
);

    vertex_t mem [`RASTER_MAX_VERTICES];

    always_ff @(posedge clk) begin
        if (i_wr) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // All three corners fetched together
    always_ff @(posedge clk) begin
        if (i_read_en) begin
            o_tri.v0 <= mem[i_raddr.i0];
            o_tri.v1 <= mem[i_raddr.i1];
            o_tri.v2 <= mem[i_raddr.i2];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_dv <= 1'b0;
        end else begin
            o_dv <= i_read_en;
        end
    end

endmodule

/* hdl/primitive_assembler.sv */
// Start is taken only when idle with i_ready high; one triangle per i_ready, finished after last
`timescale 1ns/1ns

module primitive_assembler
    import raster_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,

    input  logic         i_start,
    input  logic         i_ready,       // Downstream can take another triangle

    output logic         o_ready,
    output logic         o_finished,

    // Index buffer
    output logic         o_index_read_en,
    output logic         o_index_rewind,
    input  index_entry_t i_index,
    input  logic         i_index_dv,
    input  logic         i_index_last,

    // Vertex buffer
    output index_entry_t o_vertex_addr,
    output logic         o_vertex_read_en,
    input  triangle_t    i_vertex,
    input  logic         i_vertex_dv,

    // Assembled triangle
    output triangle_t    o_tri,
    output logic         o_dv
);

    typedef enum logic [2:0] {
        PA_IDLE,
        PA_READ_INDEX,
        PA_READ_VERTEX,
        PA_WAIT_DATA,
        PA_ASSEMBLED,
        PA_DONE
    } pa_state_t;

    pa_state_t state, next_state;
    logic      r_last;    // Current triangle is the final one

    logic      start_ok;

    assign start_ok = i_start & i_ready;

    assign o_ready        = (state == PA_IDLE);
    assign o_finished     = (state == PA_DONE);
    assign o_index_rewind = (state == PA_IDLE) & start_ok; // Pointer back to entry 0

    always_comb begin
        next_state = state;
        case (state)
            PA_IDLE: begin
                if (start_ok) begin
                    next_state = PA_READ_INDEX;
                end
            end
            PA_READ_INDEX: begin
                if (i_index_dv) begin
                    next_state = PA_READ_VERTEX;
                end
            end
            PA_READ_VERTEX: begin
                next_state = PA_WAIT_DATA;
            end
            PA_WAIT_DATA: begin
                if (i_vertex_dv) begin
                    next_state = PA_ASSEMBLED;
                end
            end
            PA_ASSEMBLED: begin
                if (r_last) begin
                    next_state = PA_DONE;
                end else if (i_ready) begin
                    next_state = PA_READ_INDEX;
                end
            end
            PA_DONE: begin
                next_state = PA_IDLE;
            end
            default: begin
                next_state = PA_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state            <= PA_IDLE;
            r_last           <= 1'b0;
            o_index_read_en  <= 1'b0;
            o_vertex_read_en <= 1'b0;
            o_dv             <= 1'b0;
        end else begin
            state            <= next_state;
            o_index_read_en  <= 1'b0; // Strobes default to one cycle
            o_vertex_read_en <= 1'b0;
            o_dv             <= 1'b0;
            case (state)
                PA_IDLE: begin
                    r_last          <= 1'b0;
                    o_index_read_en <= start_ok;
                end
                PA_READ_INDEX: begin
                    if (i_index_dv) begin
                        r_last <= i_index_last;
                    end
                end
                PA_READ_VERTEX: begin
                    o_vertex_read_en <= 1'b1;
                end
                PA_WAIT_DATA: begin
                    o_dv <= i_vertex_dv;
                end
                PA_ASSEMBLED: begin
                    o_index_read_en <= ~r_last & i_ready; // Fetch the next triangle
                end
                default: begin
                    r_last <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == PA_READ_INDEX && i_index_dv) begin
            o_vertex_addr <= i_index;
        end
        if (state == PA_WAIT_DATA && i_vertex_dv) begin
            o_tri <= i_vertex;
        end
    end

endmodule

/* hdl/triangle_cull.sv */
// Trivial reject only, no clipping; screen edges are fixed at build time
`timescale 1ns/1ns

`include "raster_consts.svh"

module triangle_cull
    import raster_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,

    input  triangle_t i_tri,
    input  logic      i_dv,
    input  logic      i_finished,

    output triangle_t o_tri,
    output logic      o_dv,
    output logic      o_finished
);

    // Outcode {left, right, top, bottom}
    function automatic logic [3:0] outcode(input vertex_t v);
        outcode[3] = $signed(v.x) < 0;
        outcode[2] = $signed(v.x) >= `RASTER_SCREEN_WIDTH;
        outcode[1] = $signed(v.y) < 0;
        outcode[0] = $signed(v.y) >= `RASTER_SCREEN_HEIGHT;
    endfunction

    logic any_invalid;
    logic off_screen;   // All corners beyond one edge
    logic keep;

    assign any_invalid = i_tri.v0.invalid | i_tri.v1.invalid | i_tri.v2.invalid;
    assign off_screen  = |(outcode(i_tri.v0) & outcode(i_tri.v1) & outcode(i_tri.v2));
    assign keep        = i_dv & ~any_invalid & ~off_screen;

    always_ff @(posedge clk) begin
        if (keep) begin
            o_tri <= i_tri;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_dv       <= 1'b0;
            o_finished <= 1'b0;
        end else begin
            o_dv       <= keep;
            o_finished <= i_finished; // Stays behind the last triangle
        end
    end

endmodule

/* hdl/geometry_top.sv */
// Buffers are loaded only while o_ready is high; i_tri_count is 1 to MAX_TRIANGLES
`timescale 1ns/1ns

`include "raster_consts.svh"

module geometry_top
    import raster_pkg::*;
(
    input  logic                       clk,
    input  logic                       rstn,

    input  logic                       i_idx_wr,
    input  logic [`RASTER_TADDR_W-1:0] i_idx_waddr,
    input  index_entry_t               i_idx_wdata,

    input  logic                       i_vtx_wr,
    input  logic [`RASTER_VADDR_W-1:0] i_vtx_waddr,
    input  vertex_t                    i_vtx_wdata,

    input  logic [`RASTER_TADDR_W:0]   i_tri_count,
    input  logic                       i_start,
    input  logic                       i_ready,

    output logic                       o_ready,
    output triangle_t                  o_tri,
    output logic                       o_tri_dv,
    output logic                       o_finished
);

    logic         index_read_en;
    logic         index_rewind;
    index_entry_t index_entry;
    logic         index_dv;
    logic         index_last;

    index_entry_t vertex_addr;
    logic         vertex_read_en;
    triangle_t    vertex_tri;
    logic         vertex_dv;

    triangle_t    asm_tri;
    logic         asm_dv;
    logic         asm_finished;

    index_buffer index_buffer_i (
        .clk       (clk),
        .rstn      (rstn),
        .i_wr      (i_idx_wr),
        .i_waddr   (i_idx_waddr),
        .i_wdata   (i_idx_wdata),
        .i_count   (i_tri_count),
        .i_rewind  (index_rewind),
        .i_read_en (index_read_en),
        .o_entry   (index_entry),
        .o_dv      (index_dv),
        .o_last    (index_last)
    );

    vertex_buffer vertex_buffer_i (
        .clk       (clk),
        .rstn      (rstn),
        .i_wr      (i_vtx_wr),
        .i_waddr   (i_vtx_waddr),
        .i_wdata   (i_vtx_wdata),
        .i_raddr   (vertex_addr),
        .i_read_en (vertex_read_en),
        .o_tri     (vertex_tri),
        .o_dv      (vertex_dv)
    );

    primitive_assembler primitive_assembler_i (
        .clk              (clk),
        .rstn             (rstn),
        .i_start          (i_start),
        .i_ready          (i_ready),
        .o_ready          (o_ready),
        .o_finished       (asm_finished),
        .o_index_read_en  (index_read_en),
        .o_index_rewind   (index_rewind),
        .i_index          (index_entry),
        .i_index_dv       (index_dv),
        .i_index_last     (index_last),
        .o_vertex_addr    (vertex_addr),
        .o_vertex_read_en (vertex_read_en),
        .i_vertex         (vertex_tri),
        .i_vertex_dv      (vertex_dv),
        .o_tri            (asm_tri),
        .o_dv             (asm_dv)
    );

    triangle_cull triangle_cull_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_tri      (asm_tri),
        .i_dv       (asm_dv),
        .i_finished (asm_finished),
        .o_tri      (o_tri),
        .o_dv       (o_tri_dv),
        .o_finished (o_finished)
    );

endmodule

/* test/tb_geometry.sv */
// Stall pattern comes from a fixed seed; the table assumes the 320x320 screen of raster_consts.svh
`timescale 1ns/1ns

`include "raster_consts.svh"

module tb_geometry
    import raster_pkg::*;
();

    localparam int NUM_VERTS      = 16;
    localparam int NUM_TRIS       = 12;
    localparam int SHORT_COUNT    = 7;
    localparam int QUIET_CYCLES   = 12;
    localparam int TIMEOUT_CYCLES = 40 * (NUM_TRIS + NUM_TRIS + SHORT_COUNT) + 200;

    logic                       clk = 1'b0;
    logic                       rstn;
    logic                       i_idx_wr;
    logic [`RASTER_TADDR_W-1:0] i_idx_waddr;
    index_entry_t               i_idx_wdata;
    logic                       i_vtx_wr;
    logic [`RASTER_VADDR_W-1:0] i_vtx_waddr;
    vertex_t                    i_vtx_wdata;
    logic [`RASTER_TADDR_W:0]   i_tri_count;
    logic                       i_start;
    logic                       i_ready;
    logic                       o_ready;
    triangle_t                  o_tri;
    logic                       o_tri_dv;
    logic                       o_finished;

    // Indexed by the same address widths as the buffers
    vertex_t      vtx_table [`RASTER_MAX_VERTICES];
    index_entry_t idx_table [`RASTER_MAX_TRIANGLES];

    triangle_t exp_q [$];      // Grows across all runs
    int        exp_pos        = 0;
    int        finished_count = 0;
    int        runs_started   = 0;
    int        cycle_count    = 0;

    always #5 clk = ~clk;

    geometry_top geometry_top_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_idx_wr    (i_idx_wr),
        .i_idx_waddr (i_idx_waddr),
        .i_idx_wdata (i_idx_wdata),
        .i_vtx_wr    (i_vtx_wr),
        .i_vtx_waddr (i_vtx_waddr),
        .i_vtx_wdata (i_vtx_wdata),
        .i_tri_count (i_tri_count),
        .i_start     (i_start),
        .i_ready     (i_ready),
        .o_ready     (o_ready),
        .o_tri       (o_tri),
        .o_tri_dv    (o_tri_dv),
        .o_finished  (o_finished)
    );

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_triangle(input triangle_t got, input triangle_t exp, input int num);
        if (got !== exp) begin
            $display("FAIL o_tri (output %0d): got %h, expected %h", num, got, exp);
            stop_run();
        end
    endtask

    function automatic vertex_t make_vertex(input int x, input int y, input int z,
                                            input logic inv);
        vertex_t v;
        v.x       = x[`RASTER_DATAWIDTH-1:0];
        v.y       = y[`RASTER_DATAWIDTH-1:0];
        v.z       = z[`RASTER_DATAWIDTH-1:0];
        v.invalid = inv;
        return v;
    endfunction

    function automatic index_entry_t make_entry(input int a, input int b, input int c);
        index_entry_t e;
        e.i0 = a[`RASTER_VADDR_W-1:0];
        e.i1 = b[`RASTER_VADDR_W-1:0];
        e.i2 = c[`RASTER_VADDR_W-1:0];
        return e;
    endfunction

    // Drawn unless a corner is invalid or every corner lies beyond one screen edge
    function automatic logic survives(input triangle_t t);
        int   x0, x1, x2;
        int   y0, y1, y2;
        logic outside;
        x0 = int'($signed(t.v0.x));
        x1 = int'($signed(t.v1.x));
        x2 = int'($signed(t.v2.x));
        y0 = int'($signed(t.v0.y));
        y1 = int'($signed(t.v1.y));
        y2 = int'($signed(t.v2.y));
        outside = (x0 < 0 && x1 < 0 && x2 < 0)
               || (x0 >= `RASTER_SCREEN_WIDTH && x1 >= `RASTER_SCREEN_WIDTH
                   && x2 >= `RASTER_SCREEN_WIDTH)
               || (y0 < 0 && y1 < 0 && y2 < 0)
               || (y0 >= `RASTER_SCREEN_HEIGHT && y1 >= `RASTER_SCREEN_HEIGHT
                   && y2 >= `RASTER_SCREEN_HEIGHT);
        return !(t.v0.invalid || t.v1.invalid || t.v2.invalid || outside);
    endfunction

    task automatic fill_tables();
        vtx_table[0]  = make_vertex(10, 10, 5, 1'b0);      // On screen
        vtx_table[1]  = make_vertex(100, 20, 6, 1'b0);
        vtx_table[2]  = make_vertex(50, 200, 7, 1'b0);
        vtx_table[3]  = make_vertex(300, 300, 8, 1'b0);
        vtx_table[4]  = make_vertex(-50, 100, 9, 1'b0);    // Left of screen
        vtx_table[5]  = make_vertex(200, 400, 10, 1'b0);   // Below screen
        vtx_table[6]  = make_vertex(-10, 50, 0, 1'b0);
        vtx_table[7]  = make_vertex(-200, 150, 1, 1'b0);
        vtx_table[8]  = make_vertex(-5, -20, 2, 1'b0);     // Left and above
        vtx_table[9]  = make_vertex(320, 10, 3, 1'b0);     // Right edge exactly
        vtx_table[10] = make_vertex(500, 250, 4, 1'b0);
        vtx_table[11] = make_vertex(40, -1, 5, 1'b0);
        vtx_table[12] = make_vertex(250, -100, 6, 1'b0);
        vtx_table[13] = make_vertex(60, 320, 7, 1'b0);
        vtx_table[14] = make_vertex(150, 2000, 8, 1'b0);
        vtx_table[15] = make_vertex(120, 120, 9, 1'b1);    // Invalid but on screen
        idx_table[0]  = make_entry(0, 1, 2);
        idx_table[1]  = make_entry(1, 3, 2);
        idx_table[2]  = make_entry(0, 4, 2);   // Partly left
        idx_table[3]  = make_entry(6, 7, 8);   // Wholly left
        idx_table[4]  = make_entry(3, 5, 1);   // Partly below
        idx_table[5]  = make_entry(9, 10, 9);  // Wholly right
        idx_table[6]  = make_entry(11, 12, 8); // Wholly above
        idx_table[7]  = make_entry(0, 15, 2);
        idx_table[8]  = make_entry(13, 14, 5); // Wholly below
        idx_table[9]  = make_entry(4, 6, 0);
        idx_table[10] = make_entry(9, 10, 1);  // Partly right
        idx_table[11] = make_entry(2, 1, 15);
    endtask

    task automatic load_buffers();
        for (int n = 0; n < NUM_VERTS; n++) begin
            @(negedge clk);
            i_vtx_wr    = 1'b1;
            i_vtx_waddr = n[`RASTER_VADDR_W-1:0];
            i_vtx_wdata = vtx_table[n[`RASTER_VADDR_W-1:0]];
        end
        for (int n = 0; n < NUM_TRIS; n++) begin
            @(negedge clk);
            i_vtx_wr    = 1'b0;
            i_idx_wr    = 1'b1;
            i_idx_waddr = n[`RASTER_TADDR_W-1:0];
            i_idx_wdata = idx_table[n[`RASTER_TADDR_W-1:0]];
        end
        @(negedge clk);
        i_idx_wr = 1'b0;
    endtask

    task automatic do_run(input int count, input logic random_ready, input logic busy_start);
        triangle_t   t;
        index_entry_t e;
        int          waited;
        int unsigned rnd;
        for (int n = 0; n < count; n++) begin
            e    = idx_table[n[`RASTER_TADDR_W-1:0]];
            t.v0 = vtx_table[e.i0];
            t.v1 = vtx_table[e.i1];
            t.v2 = vtx_table[e.i2];
            if (survives(t)) begin
                exp_q.push_back(t);
            end
        end
        runs_started++;
        @(negedge clk);
        i_tri_count = count[`RASTER_TADDR_W:0];
        i_ready     = 1'b1;
        i_start     = 1'b1;
        @(negedge clk);
        i_start = 1'b0;
        check_bit("o_ready", o_ready, 1'b0);
        waited = 0;
        while (finished_count < runs_started) begin
            @(negedge clk);
            waited++;
            i_start = busy_start && (waited == 4);  // Must be ignored
            if (random_ready) begin
                rnd     = $urandom;
                i_ready = rnd[0];
            end
        end
        i_start = 1'b0;
        i_ready = 1'b1;
        // Nothing more may come out once finished
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_bit("o_tri_dv", o_tri_dv, 1'b0);
            check_bit("o_finished", o_finished, 1'b0);
            check_bit("o_ready", o_ready, 1'b1);
        end
        if (finished_count != runs_started) begin
            $display("o_finished pulsed %0d times over %0d runs", finished_count, runs_started);
            stop_run();
        end
    endtask

    // Output monitor
    always @(negedge clk) begin
        if (rstn) begin
            if (o_tri_dv) begin
                if (exp_pos >= exp_q.size()) begin
                    $display("A triangle came out although none was left to expect");
                    stop_run();
                end else begin
                    check_triangle(o_tri, exp_q[exp_pos], exp_pos);
                    exp_pos++;
                end
            end
            if (o_finished) begin
                if (exp_pos != exp_q.size()) begin
                    $display("o_finished came before all expected triangles had arrived");
                    stop_run();
                end
                check_bit("o_ready", o_ready, 1'b1);
                finished_count <= finished_count + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the runs did not complete within %0d cycles", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    initial begin
        rstn        = 1'b0;
        i_idx_wr    = 1'b0;
        i_idx_waddr = '0;
        i_idx_wdata = '0;
        i_vtx_wr    = 1'b0;
        i_vtx_waddr = '0;
        i_vtx_wdata = '0;
        i_tri_count = '0;
        i_start     = 1'b0;
        i_ready     = 1'b1;
        void'($urandom(32'h8c0c7526));
        fill_tables();
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        check_bit("o_ready", o_ready, 1'b1);
        check_bit("o_tri_dv", o_tri_dv, 1'b0);
        check_bit("o_finished", o_finished, 1'b0);
        load_buffers();
        do_run(NUM_TRIS, 1'b0, 1'b0);      // Downstream always ready
        do_run(NUM_TRIS, 1'b1, 1'b0);      // Random back-pressure
        do_run(SHORT_COUNT, 1'b0, 1'b1);   // Shorter list, extra start mid-run
        $display("Testbench passed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/raster_pkg.sv
hdl/index_buffer.sv
hdl/vertex_buffer.sv
hdl/primitive_assembler.sv
hdl/triangle_cull.sv
hdl/geometry_top.sv
test/tb_geometry.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_geometry -o tb_geometry \
    > build.log 2>&1 || { cat build.log; echo "Build error"; exit 1; }
./obj_dir/tb_geometry > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
